/* rtl/fas_pkg.sv */
package fas_pkg;

	typedef logic signed [15:0] sample_t;    // input and FIR output sample
	typedef logic signed [31:0] acc_t;       // FIR product and sum
	typedef logic signed [23:0] fft_t;       // one real or imaginary FFT value
	typedef logic signed [23:0] tw_t;        // twiddle component, Q16
	typedef logic [3:0]         bin_t;       // bin or memory index
	typedef logic [2:0]         idx_t;       // butterfly index within a stage
	typedef logic [1:0]         stage_t;
	typedef logic [32:0]        pwr_t;       // bin power

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_RUN,
		ST_SCAN
	} fft_state_t;

	localparam int FIR_TAPS   = 32;
	localparam int FIR_HALF   = 16;
	localparam int FFT_N      = 16;
	localparam int FFT_STAGES = 4;
	localparam int FFT_FRAC   = 8;     // zero bits below a loaded sample
	localparam int TW_FRAC    = 16;

	// low-pass taps, symmetric so only the first half is stored
	localparam sample_t FIR_COEF [FIR_HALF] = '{
		16'hFF9E,
		16'hFF86,
		16'hFFA7,
		16'h003B,
		16'h014B,
		16'h024A,
		16'h0222,
		16'hFFE4,
		16'hFBC5,
		16'hF7CA,
		16'hF74E,
		16'hFD74,
		16'h0B1A,
		16'h1DAC,
		16'h2F9E,
		16'h3AA9
	};

	// W^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
	localparam tw_t TW_RE [8] = '{
		24'sd65536,
		24'sd60547,
		24'sd46341,
		24'sd25080,
		24'sd0,
		-24'sd25080,
		-24'sd46341,
		-24'sd60547
	};

	localparam tw_t TW_IM [8] = '{
		24'sd0,
		-24'sd25080,
		-24'sd46341,
		-24'sd60547,
		-24'sd65536,
		-24'sd60547,
		-24'sd46341,
		-24'sd25080
	};

endpackage

/* rtl/fas_top.sv */
module fas_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             data_valid,
	input  fas_pkg::sample_t data,
	output logic             ready,
	output logic             fir_valid,
	output fas_pkg::sample_t fir_d,
	output logic             done,
	output fas_pkg::bin_t    freq,
	output fas_pkg::pwr_t    peak_pwr
);

	fas_pkg::bin_t load_addr;
	logic          bf_wr;
	fas_pkg::bin_t addr_a;
	fas_pkg::bin_t addr_b;
	fas_pkg::idx_t tw_idx;
	logic          scan_valid;
	logic          scan_last;
	fas_pkg::fft_t rd_a_re;
	fas_pkg::fft_t rd_a_im;
	fas_pkg::fft_t rd_b_re;
	fas_pkg::fft_t rd_b_im;
	fas_pkg::fft_t wd_a_re;
	fas_pkg::fft_t wd_a_im;
	fas_pkg::fft_t wd_b_re;
	fas_pkg::fft_t wd_b_im;

	fir_filter u_fir (
		.clk(clk), .rst(rst), .data_valid(data_valid), .ready(ready),
		.data(data), .fir_valid(fir_valid), .fir_d(fir_d)
	);

	fft_ctrl u_ctrl (
		.clk(clk), .rst(rst), .fir_valid(fir_valid), .ready(ready),
		.load_addr(load_addr), .bf_wr(bf_wr), .addr_a(addr_a), .addr_b(addr_b),
		.tw_idx(tw_idx), .scan_valid(scan_valid), .scan_last(scan_last)
	);

	fft_mem u_mem (
		.clk(clk), .rst(rst), .fir_valid(fir_valid), .load_addr(load_addr),
		.fir_d(fir_d), .bf_wr(bf_wr), .addr_a(addr_a), .addr_b(addr_b),
		.wd_a_re(wd_a_re), .wd_a_im(wd_a_im), .wd_b_re(wd_b_re), .wd_b_im(wd_b_im),
		.rd_a_re(rd_a_re), .rd_a_im(rd_a_im), .rd_b_re(rd_b_re), .rd_b_im(rd_b_im)
	);

	fft_butterfly u_bf (
		.a_re(rd_a_re), .a_im(rd_a_im), .b_re(rd_b_re), .b_im(rd_b_im),
		.tw_idx(tw_idx),
		.y_a_re(wd_a_re), .y_a_im(wd_a_im), .y_b_re(wd_b_re), .y_b_im(wd_b_im)
	);

	// port a doubles as the scan read port
	peak_detector u_peak (
		.clk(clk), .rst(rst), .scan_valid(scan_valid), .scan_last(scan_last),
		.scan_bin(addr_a), .bin_re(rd_a_re), .bin_im(rd_a_im),
		.done(done), .freq(freq), .peak_pwr(peak_pwr)
	);

endmodule

/* rtl/fft_butterfly.sv */
module fft_butterfly (
	input  fas_pkg::fft_t a_re,
	input  fas_pkg::fft_t a_im,
	input  fas_pkg::fft_t b_re,
	input  fas_pkg::fft_t b_im,
	input  fas_pkg::idx_t tw_idx,
	output fas_pkg::fft_t y_a_re,
	output fas_pkg::fft_t y_a_im,
	output fas_pkg::fft_t y_b_re,
	output fas_pkg::fft_t y_b_im
);

	fas_pkg::tw_t       w_re;
	fas_pkg::tw_t       w_im;
	logic signed [47:0] p_rr;
	logic signed [47:0] p_ii;
	logic signed [47:0] p_ri;
	logic signed [47:0] p_ir;
	logic signed [48:0] m_re;
	logic signed [48:0] m_im;
	fas_pkg::fft_t      t_re;
	fas_pkg::fft_t      t_im;
	logic signed [24:0] sum_re;
	logic signed [24:0] sum_im;
	logic signed [24:0] dif_re;
	logic signed [24:0] dif_im;

	assign w_re = fas_pkg::TW_RE[tw_idx];
	assign w_im = fas_pkg::TW_IM[tw_idx];

	assign p_rr = b_re * w_re;
	assign p_ii = b_im * w_im;
	assign p_ri = b_re * w_im;
	assign p_ir = b_im * w_re;

	// full precision complex product, then back from Q16 (floor)
	assign m_re = 49'(p_rr) - 49'(p_ii);
	assign m_im = 49'(p_ri) + 49'(p_ir);
	assign t_re = fas_pkg::fft_t'(m_re >>> fas_pkg::TW_FRAC);
	assign t_im = fas_pkg::fft_t'(m_im >>> fas_pkg::TW_FRAC);

	assign sum_re = 25'(a_re) + 25'(t_re);
	assign sum_im = 25'(a_im) + 25'(t_im);
	assign dif_re = 25'(a_re) - 25'(t_re);
	assign dif_im = 25'(a_im) - 25'(t_im);

	// halved every stage to keep the frame in 24 bits
	assign y_a_re = sum_re[24:1];
	assign y_a_im = sum_im[24:1];
	assign y_b_re = dif_re[24:1];
	assign y_b_im = dif_im[24:1];

endmodule

/* rtl/fft_ctrl.sv */
module fft_ctrl (
	input  logic          clk,
	input  logic          rst,
	input  logic          fir_valid,
	output logic          ready,
	output fas_pkg::bin_t load_addr,
	output logic          bf_wr,
	output fas_pkg::bin_t addr_a,
	output fas_pkg::bin_t addr_b,
	output fas_pkg::idx_t tw_idx,
	output logic          scan_valid,
	output logic          scan_last
);

	fas_pkg::fft_state_t state;
	fas_pkg::bin_t       cnt;      // load position, later the scanned bin
	fas_pkg::stage_t     stage;
	fas_pkg::idx_t       bf;       // butterfly within the stage
	fas_pkg::bin_t       top;
	fas_pkg::bin_t       bot;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= fas_pkg::ST_LOAD;
			cnt   <= '0;
			stage <= '0;
			bf    <= '0;
		end else begin
			case (state)
				fas_pkg::ST_LOAD: begin
					if (fir_valid) begin
						cnt <= cnt + 4'd1;
						if (cnt == 4'(fas_pkg::FFT_N - 1)) begin
							state <= fas_pkg::ST_RUN;
						end
					end
				end
				fas_pkg::ST_RUN: begin
					bf <= bf + 3'd1;    // wraps into the next stage
					if (bf == 3'd7) begin
						stage <= stage + 2'd1;
						if (stage == 2'(fas_pkg::FFT_STAGES - 1)) begin
							state <= fas_pkg::ST_SCAN;
						end
					end
				end
				fas_pkg::ST_SCAN: begin
					cnt <= cnt + 4'd1;
					if (cnt == 4'(fas_pkg::FFT_N - 1)) begin
						state <= fas_pkg::ST_LOAD;
					end
				end
				default: state <= fas_pkg::ST_LOAD;
			endcase
		end
	end

	// top index has a zero inserted at bit position stage
	always_comb begin
		case (stage)
			2'd0: begin
				top    = {bf, 1'b0};
				bot    = {bf, 1'b1};
				tw_idx = 3'd0;
			end
			2'd1: begin
				top    = {bf[2:1], 1'b0, bf[0]};
				bot    = {bf[2:1], 1'b1, bf[0]};
				tw_idx = {bf[0], 2'b00};
			end
			2'd2: begin
				top    = {bf[2], 1'b0, bf[1:0]};
				bot    = {bf[2], 1'b1, bf[1:0]};
				tw_idx = {bf[1:0], 1'b0};
			end
			default: begin
				top    = {1'b0, bf};
				bot    = {1'b1, bf};
				tw_idx = bf;
			end
		endcase
	end

	assign ready      = (state == fas_pkg::ST_LOAD);
	assign load_addr  = {cnt[0], cnt[1], cnt[2], cnt[3]};    // bit-reversed
	assign bf_wr      = (state == fas_pkg::ST_RUN);
	assign addr_a     = bf_wr ? top : cnt;
	assign addr_b     = bot;
	assign scan_valid = (state == fas_pkg::ST_SCAN);
	assign scan_last  = scan_valid && (cnt == 4'(fas_pkg::FFT_N - 1));

endmodule

/* rtl/fft_mem.sv */
module fft_mem (
	input  logic             clk,
	input  logic             rst,
	input  logic             fir_valid,
	input  fas_pkg::bin_t    load_addr,
	input  fas_pkg::sample_t fir_d,
	input  logic             bf_wr,
	input  fas_pkg::bin_t    addr_a,
	input  fas_pkg::bin_t    addr_b,
	input  fas_pkg::fft_t    wd_a_re,
	input  fas_pkg::fft_t    wd_a_im,
	input  fas_pkg::fft_t    wd_b_re,
	input  fas_pkg::fft_t    wd_b_im,
	output fas_pkg::fft_t    rd_a_re,
	output fas_pkg::fft_t    rd_a_im,
	output fas_pkg::fft_t    rd_b_re,
	output fas_pkg::fft_t    rd_b_im
);

	fas_pkg::fft_t mem_re [fas_pkg::FFT_N];
	fas_pkg::fft_t mem_im [fas_pkg::FFT_N];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < fas_pkg::FFT_N; i++) begin
				mem_re[i] <= '0;
				mem_im[i] <= '0;
			end
		end else if (fir_valid) begin
			mem_re[load_addr] <= {fir_d, {fas_pkg::FFT_FRAC{1'b0}}};    // real input only
			mem_im[load_addr] <= '0;
		end else if (bf_wr) begin
			mem_re[addr_a] <= wd_a_re;    // in place
			mem_im[addr_a] <= wd_a_im;
			mem_re[addr_b] <= wd_b_re;
			mem_im[addr_b] <= wd_b_im;
		end
	end

	assign rd_a_re = mem_re[addr_a];
	assign rd_a_im = mem_im[addr_a];
	assign rd_b_re = mem_re[addr_b];
	assign rd_b_im = mem_im[addr_b];

endmodule

/* rtl/fir_filter.sv */
module fir_filter (
	input  logic             clk,
	input  logic             rst,
	input  logic             data_valid,
	input  logic             ready,
	input  fas_pkg::sample_t data,
	output logic             fir_valid,
	output fas_pkg::sample_t fir_d
);

	logic               accept;
	logic [5:0]         fill;      // accepted samples, saturating
	logic               full;
	fas_pkg::sample_t   hist [fas_pkg::FIR_TAPS];
	logic signed [16:0] pre  [fas_pkg::FIR_HALF];
	fas_pkg::acc_t      prod [fas_pkg::FIR_HALF];
	fas_pkg::acc_t      lvl1 [8];
	fas_pkg::acc_t      lvl2 [4];
	fas_pkg::acc_t      lvl3 [2];
	fas_pkg::acc_t      sum;

	assign accept    = data_valid & ready;
	assign full      = (fill == 6'(fas_pkg::FIR_TAPS));
	assign fir_valid = accept & full;    // output uses the history before this sample

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fill <= '0;
		end else if (accept && !full) begin
			fill <= fill + 6'd1;
		end
	end

	// hist[0] is the newest sample
	always_ff @(posedge clk) begin
		if (accept) begin
			hist[0] <= data;
			for (int i = 1; i < fas_pkg::FIR_TAPS; i++) begin
				hist[i] <= hist[i-1];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < fas_pkg::FIR_HALF; i++) begin
			pre[i]  = 17'(hist[i]) + 17'(hist[fas_pkg::FIR_TAPS-1-i]);    // folded taps
			prod[i] = pre[i] * fas_pkg::FIR_COEF[i];    // wraps to 32 bits
		end
		for (int i = 0; i < 8; i++) begin
			lvl1[i] = prod[2*i] + prod[2*i+1];
		end
		for (int i = 0; i < 4; i++) begin
			lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
		end
		for (int i = 0; i < 2; i++) begin
			lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
		end
		sum = lvl3[0] + lvl3[1];
	end

	// upper half, nudged up by one for negative sums
	assign fir_d = sum[31:16] + {15'd0, sum[31]};

endmodule

/* rtl/peak_detector.sv */
module peak_detector (
	input  logic          clk,
	input  logic          rst,
	input  logic          scan_valid,
	input  logic          scan_last,
	input  fas_pkg::bin_t scan_bin,
	input  fas_pkg::fft_t bin_re,
	input  fas_pkg::fft_t bin_im,
	output logic          done,
	output fas_pkg::bin_t freq,
	output fas_pkg::pwr_t peak_pwr
);

	logic signed [7:0]  re_hi;
	logic signed [7:0]  im_hi;
	logic signed [15:0] re_sq;
	logic signed [15:0] im_sq;
	fas_pkg::pwr_t      cur_pwr;
	fas_pkg::bin_t      best_bin;
	fas_pkg::pwr_t      best_pwr;
	logic               take;
	fas_pkg::bin_t      nxt_bin;
	fas_pkg::pwr_t      nxt_pwr;

	assign re_hi   = bin_re[23:16];
	assign im_hi   = bin_im[23:16];
	assign re_sq   = re_hi * re_hi;
	assign im_sq   = im_hi * im_hi;
	assign cur_pwr = fas_pkg::pwr_t'(re_sq) + fas_pkg::pwr_t'(im_sq);

	// strict compare keeps the lowest bin on a tie
	assign take    = (scan_bin == 4'd0) || (cur_pwr > best_pwr);
	assign nxt_bin = take ? scan_bin : best_bin;
	assign nxt_pwr = take ? cur_pwr : best_pwr;

	always_ff @(posedge clk) begin
		if (scan_valid) begin
			best_bin <= nxt_bin;
			best_pwr <= nxt_pwr;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			done     <= 1'b0;
			freq     <= '0;
			peak_pwr <= '0;
		end else begin
			done <= scan_valid & scan_last;    // one-cycle pulse
			if (scan_valid && scan_last) begin
				freq     <= nxt_bin;
				peak_pwr <= nxt_pwr;
			end
		end
	end

endmodule

/* sources.f */
rtl/fas_pkg.sv
rtl/fir_filter.sv
rtl/fft_mem.sv
rtl/fft_ctrl.sv
rtl/fft_butterfly.sv
rtl/peak_detector.sv
rtl/fas_top.sv
tb/tb_fas.sv

/* tb/tb_fas.sv */
module tb_fas;

	localparam int N_CYCLES = 2000;    // offered cycles over all phases
	localparam int LIMIT    = N_CYCLES * 4 + (N_CYCLES / 16) * 60 + 100;

	// W^k in Q16, cosine and minus sine of 2*pi*k/16
	localparam longint TW_COS [8] = '{65536, 60547, 46341, 25080, 0, -25080, -46341, -60547};
	localparam longint TW_MSIN [8] = '{0, -25080, -46341, -60547, -65536, -60547, -46341, -25080};

	logic             clk;
	logic             rst;
	logic             data_valid;
	fas_pkg::sample_t data;
	logic             ready;
	logic             fir_valid;
	fas_pkg::sample_t fir_d;
	logic             done;
	fas_pkg::bin_t    freq;
	fas_pkg::pwr_t    peak_pwr;

	integer seed = 86;
	int     cycles = 0;
	int     hist_m [32];      // accepted samples, [0] newest
	int     n_acc = 0;
	longint fre [16];
	longint fim [16];
	int     frame_cnt = 0;
	bit     frame_const = 1;  // every output of this frame saw a constant history
	int     run_val = 0;
	int     run_len = 0;
	bit     busy = 0;         // frame handed to the FFT, done not yet seen
	int     frames_formed = 0;
	int     done_count = 0;
	int     exp_freq_q [$];
	longint exp_pwr_q [$];
	bit     const_q [$];
	int     val_q [$];

	logic             acc;
	logic             exp_valid;
	fas_pkg::sample_t exp_d;
	int               pend_freq;
	longint           pend_pwr;
	bit               pend_const;
	int               pend_val;

	fas_top fas_top_i (
		.clk(clk), .rst(rst), .data_valid(data_valid), .data(data),
		.ready(ready), .fir_valid(fir_valid), .fir_d(fir_d),
		.done(done), .freq(freq), .peak_pwr(peak_pwr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_failed();
		$display("Result: FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// four-state compare so an unknown output never slips through
	task automatic check(input string name, input logic signed [63:0] got,
			input logic signed [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t signal %s got %0d expected %0d",
				$time, name, got, exp);
			stop_failed();
		end
	endtask

	function automatic int bit_reverse4(input int n);
		bit_reverse4 = ((n & 1) << 3) | ((n & 2) << 1) | ((n & 4) >> 1) | ((n & 8) >> 3);
	endfunction

	function automatic longint wrap24(input longint x);
		logic signed [23:0] v;
		v = x[23:0];
		wrap24 = v;
	endfunction

	// folded taps over the 32 samples before the current one
	function automatic logic signed [15:0] fir_model();
		logic signed [31:0] sum;
		logic signed [63:0] prod;
		longint             pre;
		sum = 0;
		for (int i = 0; i < 16; i++) begin
			pre  = hist_m[i] + hist_m[31-i];
			prod = pre * longint'(fas_pkg::FIR_COEF[i]);
			sum  = sum + prod[31:0];    // 32-bit wrap
		end
		fir_model = sum[31:16] + ((sum < 0) ? 1 : 0);
	endfunction

	// in-place radix-2 FFT, halved per stage, then the peak search
	task automatic transform_frame();
		int     span;
		int     top;
		int     bot;
		int     k;
		longint tr;
		longint ti;
		longint ar;
		longint ai;
		longint rh;
		longint ih;
		longint p;
		longint best_p;
		int     best_k;
		for (int s = 0; s < 4; s++) begin
			span = 1 << s;
			for (int j = 0; j < 8; j++) begin
				top = (j / span) * 2 * span + (j % span);
				bot = top + span;
				k   = (j % span) * (8 / span);
				tr  = wrap24((fre[bot] * TW_COS[k] - fim[bot] * TW_MSIN[k]) >>> 16);
				ti  = wrap24((fre[bot] * TW_MSIN[k] + fim[bot] * TW_COS[k]) >>> 16);
				ar  = fre[top];
				ai  = fim[top];
				fre[top] = wrap24((ar + tr) >>> 1);
				fim[top] = wrap24((ai + ti) >>> 1);
				fre[bot] = wrap24((ar - tr) >>> 1);
				fim[bot] = wrap24((ai - ti) >>> 1);
			end
		end
		best_p = -1;
		best_k = 0;
		for (int b = 0; b < 16; b++) begin
			rh = fre[b] >>> 16;    // bits 23:16
			ih = fim[b] >>> 16;
			p  = rh * rh + ih * ih;
			if (p > best_p) begin  // strict, lowest bin wins
				best_p = p;
				best_k = b;
			end
		end
		exp_freq_q.push_back(best_k);
		exp_pwr_q.push_back(best_p);
	endtask

	// model and checks, sampled mid-cycle where everything is settled
	always @(negedge clk) begin
		if (!rst) begin
			if (done) begin
				if (exp_freq_q.size() == 0) begin
					$display("done pulsed at time %0t but the model has no finished frame", $time);
					stop_failed();
				end else begin
					pend_freq  = exp_freq_q.pop_front();
					pend_pwr   = exp_pwr_q.pop_front();
					pend_const = const_q.pop_front();
					pend_val   = val_q.pop_front();
					check("freq", freq, pend_freq);
					check("peak_pwr", peak_pwr, pend_pwr);
					if (pend_const) begin
						check("freq", freq, 0);    // constant input, all energy in bin 0
					end
					if (pend_const && pend_val == 0) begin
						check("peak_pwr", peak_pwr, 0);
					end
					done_count++;
					busy = 1'b0;
				end
			end
			check("ready", ready, !busy);
			acc       = data_valid && ready;
			exp_valid = acc && (n_acc >= 32);
			check("fir_valid", fir_valid, exp_valid);
			if (exp_valid) begin
				exp_d = fir_model();
				check("fir_d", fir_d, exp_d);
				fre[bit_reverse4(frame_cnt)] = longint'(exp_d) * 256;
				fim[bit_reverse4(frame_cnt)] = 0;
				if (run_len < 32) begin
					frame_const = 1'b0;
				end
				frame_cnt++;
				if (frame_cnt == 16) begin
					transform_frame();
					const_q.push_back(frame_const);
					val_q.push_back(run_val);
					frames_formed++;
					frame_cnt   = 0;
					frame_const = 1'b1;
					busy        = 1'b1;
				end
			end
			if (acc) begin
				for (int i = 31; i > 0; i--) begin
					hist_m[i] = hist_m[i-1];
				end
				hist_m[0] = data;
				n_acc++;
				if (run_len > 0 && int'(data) == run_val) begin
					run_len++;
				end else begin
					run_val = data;
					run_len = 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			stop_failed();
		end
	end

	// mode 0 random, 1 all zero, 2 constant; modes 1 and 2 offer every cycle
	task automatic drive_phase(input int mode, input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
			case (mode)
				0: begin
					data_valid = ($random(seed) & 3) != 0;
					data       = $random(seed);
				end
				1: begin
					data_valid = 1'b1;
					data       = 16'sd0;
				end
				default: begin
					data_valid = 1'b1;
					data       = 16'sd12000;
				end
			endcase
		end
	endtask

	initial begin
		rst        = 1'b1;
		data_valid = 1'b0;
		data       = '0;
		repeat (2) @(posedge clk);
		#10 rst = 1'b0;
		@(negedge clk);
		check("ready", ready, 1);
		check("fir_valid", fir_valid, 0);
		check("done", done, 0);
		drive_phase(0, 800);
		drive_phase(1, 400);
		drive_phase(2, 400);
		drive_phase(0, 400);
		@(posedge clk);
		#10 data_valid = 1'b0;
		while (busy) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		check("done count", done_count, frames_formed);
		$display("Result: PASSED");
		$finish;
	end

endmodule
